// ==== Bender.yml ====
package:
  name: execLane

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/lanePkg.sv
      - source/issueDecoder.sv
      - source/mathPipe.sv
      - source/ringBuffer.sv
      - source/writeBackSelect.sv
      - source/execLane.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/execLane_asserts.sv
      - verif/execLaneTb.sv

// ==== execLane.f ====
+incdir+include
source/lanePkg.sv
source/issueDecoder.sv
source/mathPipe.sv
source/ringBuffer.sv
source/writeBackSelect.sv
source/execLane.sv
verif/execLane_asserts.sv
verif/execLaneTb.sv

// ==== include/lane_defines.svh ====
// Lane defines: widths and depths shared across the vector execution lane
`ifndef LANE_DEFINES_SVH
`define LANE_DEFINES_SVH

////////////////////
// Datapath widths
////////////////////

`define LANE_DATA_W		32		// Integer operand and result width
`define LANE_ISSUE_W	4		// Wrapping issue number
`define LANE_DST_W		4		// Destination register index

////////////////////
// Depths
////////////////////

// Four math stages plus eight queued moves stay below the 16 issue numbers,
// so no two items in flight ever carry the same tag
`define LANE_MATH_DEPTH	4		// Arithmetic pipeline stages
`define LANE_MOVE_DEPTH	8		// Move ring buffer entries

`endif

// ==== source/execLane.sv ====
// Execution lane: issue decoder, math pipe, move buffers and write-back select
`timescale 1ns/1ps
`default_nettype none
`include "lane_defines.svh"

module execLane (
	input	wire logic						clock,
	input	wire logic						rst,
	input	wire logic						req,			// Command request
	input	wire lanePkg::opCode_t			op,
	input	wire lanePkg::regIdx_t			dst,
	input	wire lanePkg::data_t			srcA,
	input	wire lanePkg::data_t			srcB,
	input	wire lanePkg::data_t			srcC,
	output	logic							issueStall,		// Issuer must hold
	output	logic							wbValid,
	output	lanePkg::wbToken_t				wbToken,
	output	lanePkg::data_t					wbData
);

	import lanePkg::*;

	logic							mathIssue;
	logic							moveWrite;
	logic							moveRead;
	logic							moveFull;
	logic							moveEmpty;
	wbToken_t						issueToken;

	logic							mathValid;
	logic							mathBusy;
	wbToken_t						mathToken;
	data_t							mathData;

	wbToken_t						moveToken;		// Head of the move queue
	data_t							moveData;

	issueDecoder decoder (
		.clock(			clock			),
		.rst(			rst				),
		.req(			req				),
		.op(			op				),
		.dst(			dst				),
		.moveFull(		moveFull		),
		.moveEmpty(		moveEmpty		),
		.issueStall(	issueStall		),
		.mathIssue(		mathIssue		),
		.moveWrite(		moveWrite		),
		.issueToken(	issueToken		)
	);

	mathPipe mathUnit (
		.clock(			clock			),
		.rst(			rst				),
		.mathIssue(		mathIssue		),
		.token(			issueToken		),
		.srcA(			srcA			),
		.srcB(			srcB			),
		.srcC(			srcC			),
		.mathValid(		mathValid		),
		.mathToken(		mathToken		),
		.mathData(		mathData		),
		.mathBusy(		mathBusy		)
	);

	////////////////////
	// Move queue
	////////////////////

	ringBuffer #(
		.TYPE(			wbToken_t			),
		.NumEntry(		`LANE_MOVE_DEPTH	)
	) moveTokenBuf (
		.clock(			clock			),
		.rst(			rst				),
		.we(			moveWrite		),
		.re(			moveRead		),
		.dataIn(		issueToken		),
		.dataOut(		moveToken		),
		.full(			moveFull		),
		.empty(			moveEmpty		)
	);

	// Same pointers as the token buffer, so its levels are left open
	ringBuffer #(
		.TYPE(			data_t				),
		.NumEntry(		`LANE_MOVE_DEPTH	)
	) moveDataBuf (
		.clock(			clock			),
		.rst(			rst				),
		.we(			moveWrite		),
		.re(			moveRead		),
		.dataIn(		srcA			),
		.dataOut(		moveData		),
		.full(							),
		.empty(							)
	);

	writeBackSelect wbSelect (
		.clock(			clock			),
		.rst(			rst				),
		.mathValid(		mathValid		),
		.mathToken(		mathToken		),
		.mathData(		mathData		),
		.mathBusy(		mathBusy		),
		.moveEmpty(		moveEmpty		),
		.moveToken(		moveToken		),
		.moveData(		moveData		),
		.moveRead(		moveRead		),
		.wbValid(		wbValid			),
		.wbToken(		wbToken			),
		.wbData(		wbData			)
	);

endmodule

`default_nettype wire

// ==== source/issueDecoder.sv ====
// Issue decoder: numbers each command, steers it to math or move, raises the stall
`timescale 1ns/1ps
`default_nettype none
`include "lane_defines.svh"

module issueDecoder (
	input	wire logic						clock,
	input	wire logic						rst,
	input	wire logic						req,			// Command present
	input	wire lanePkg::opCode_t			op,
	input	wire lanePkg::regIdx_t			dst,			// Destination register
	input	wire logic						moveFull,		// Move buffer level
	input	wire logic						moveEmpty,		// Move buffer level
	output	logic							issueStall,		// Hold the command
	output	logic							mathIssue,		// Strobe to the math pipe
	output	logic							moveWrite,		// Strobe to the move buffer
	output	lanePkg::wbToken_t				issueToken
);

	import lanePkg::*;

	issueNo_t						issueCnt;			// Tag of the next command
	logic							isMove;
	logic							accept;

	////////////////////
	// Stall and steering
	////////////////////

	assign isMove				= ( op == opMov );

	// Math must never overtake a queued move, so it waits for an empty buffer
	assign issueStall			= req & ( isMove ? moveFull : ~moveEmpty );

	assign accept				= req & ~issueStall;
	assign mathIssue			= accept & ~isMove;
	assign moveWrite			= accept &  isMove;

	////////////////////
	// Token
	////////////////////

	assign issueToken.valid		= accept;
	assign issueToken.op		= op;
	assign issueToken.dst		= dst;
	assign issueToken.issueNo	= issueCnt;

	always_ff @(posedge clock) begin
		if ( rst ) begin
			issueCnt	<= '0;
		end else if ( accept ) begin
			issueCnt	<= issueCnt + 1'b1;		// Wraps at 16
		end
	end

endmodule

`default_nettype wire

// ==== source/lanePkg.sv ====
// Lane package: opcode, data, issue number and write-back token types
`default_nettype none
`include "lane_defines.svh"

package lanePkg;

	////////////////////
	// Scalar types
	////////////////////

	typedef logic [`LANE_DATA_W-1:0]	data_t;			// One data word
	typedef logic [`LANE_ISSUE_W-1:0]	issueNo_t;		// Wraps at 16
	typedef logic [`LANE_DST_W-1:0]		regIdx_t;		// Register index

	typedef enum logic [1:0] {
		opAdd	= 2'b00,		// srcA + srcB
		opMul	= 2'b01,		// srcA * srcB
		opMac	= 2'b10,		// srcA * srcB + srcC
		opMov	= 2'b11			// Copy of srcA
	} opCode_t;

	////////////////////
	// Write-back token
	////////////////////

	typedef struct packed {
		logic		valid;
		opCode_t	op;
		regIdx_t	dst;
		issueNo_t	issueNo;	// Program order tag
	} wbToken_t;

endpackage

`default_nettype wire

// ==== source/mathPipe.sv ====
// Math pipe: fixed-depth add, multiply and multiply-add with a token per result
`timescale 1ns/1ps
`default_nettype none
`include "lane_defines.svh"

module mathPipe (
	input	wire logic						clock,
	input	wire logic						rst,
	input	wire logic						mathIssue,		// New operation strobe
	input	wire lanePkg::wbToken_t			token,
	input	wire lanePkg::data_t			srcA,
	input	wire lanePkg::data_t			srcB,
	input	wire lanePkg::data_t			srcC,			// Addend for opMac
	output	logic							mathValid,		// Result at the last stage
	output	lanePkg::wbToken_t				mathToken,
	output	lanePkg::data_t					mathData,
	output	logic							mathBusy		// Any stage occupied
);

	import lanePkg::*;

	localparam int Depth		= `LANE_MATH_DEPTH;

	logic [Depth-1:0]				stageValid;
	wbToken_t						stageToken	[Depth];
	data_t							stageData	[Depth];
	data_t							addend;				// Held beside stage 1

	data_t							firstData;
	data_t							firstAddend;

	////////////////////
	// Stage 1 operands
	////////////////////

	always_comb begin
		firstData		= srcA;					// opAdd passes srcA
		firstAddend		= srcB;
		case ( token.op )
			opMul: begin
				firstData	= srcA * srcB;		// Low 32 bits kept
				firstAddend	= '0;
			end
			opMac: begin
				firstData	= srcA * srcB;
				firstAddend	= srcC;
			end
			default: begin
				firstData	= srcA;
				firstAddend	= srcB;
			end
		endcase
	end

	////////////////////
	// Shift pipeline
	////////////////////

	always_ff @(posedge clock) begin
		if ( rst ) begin
			stageValid	<= '0;
		end else begin
			stageValid	<= { stageValid[Depth-2:0], mathIssue };
		end
	end

	always_ff @(posedge clock) begin
		stageToken[0]	<= token;
		stageData[0]	<= firstData;
		addend			<= firstAddend;

		stageToken[1]	<= stageToken[0];
		stageData[1]	<= stageData[0] + addend;		// Sum stage

		// Remaining stages only delay the result
		for ( int i = 2; i < Depth; i++ ) begin
			stageToken[i]	<= stageToken[i-1];
			stageData[i]	<= stageData[i-1];
		end
	end

	assign mathValid			= stageValid[Depth-1];
	assign mathToken			= stageToken[Depth-1];
	assign mathData				= stageData[Depth-1];
	assign mathBusy				= |stageValid;

endmodule

`default_nettype wire

// ==== source/ringBuffer.sv ====
// Ring buffer: circular FIFO of any payload type with full and empty levels
`timescale 1ns/1ps
`default_nettype none
`include "lane_defines.svh"

module ringBuffer #(
	parameter type TYPE				= logic [31:0],
	parameter int NumEntry			= `LANE_MOVE_DEPTH
) (
	input	wire logic						clock,
	input	wire logic						rst,
	input	wire logic						we,				// Push
	input	wire logic						re,				// Pop
	input	wire TYPE						dataIn,
	output	TYPE							dataOut,		// Head entry
	output	logic							full,
	output	logic							empty
);

	localparam int PtrW			= ( NumEntry > 1 ) ? $clog2(NumEntry) : 1;
	localparam int CntW			= $clog2(NumEntry + 1);

	TYPE							mem		[NumEntry];
	logic [PtrW-1:0]				wrPtr;
	logic [PtrW-1:0]				rdPtr;
	logic [CntW-1:0]				count;
	logic							doWrite;
	logic							doRead;

	assign doWrite				= we & ~full;		// Push to a full buffer is dropped
	assign doRead				= re & ~empty;

	assign full					= ( count == CntW'(NumEntry) );
	assign empty				= ( count == '0 );
	assign dataOut				= mem[rdPtr];

	always_ff @(posedge clock) begin
		if ( rst ) begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			count	<= '0;
		end else begin
			if ( doWrite ) begin
				wrPtr	<= ( wrPtr == PtrW'(NumEntry - 1) ) ? '0 : wrPtr + 1'b1;
			end
			if ( doRead ) begin
				rdPtr	<= ( rdPtr == PtrW'(NumEntry - 1) ) ? '0 : rdPtr + 1'b1;
			end
			case ( { doWrite, doRead } )
				2'b10:		count	<= count + 1'b1;
				2'b01:		count	<= count - 1'b1;
				default:	count	<= count;			// Idle or push and pop
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ( doWrite ) begin
			mem[wrPtr]	<= dataIn;
		end
	end

endmodule

`default_nettype wire

// ==== source/writeBackSelect.sv ====
// Write-back select: picks math or move head and registers the write-back
`timescale 1ns/1ps
`default_nettype none

module writeBackSelect (
	input	wire logic						clock,
	input	wire logic						rst,
	input	wire logic						mathValid,
	input	wire lanePkg::wbToken_t			mathToken,
	input	wire lanePkg::data_t			mathData,
	input	wire logic						mathBusy,		// Older math in flight
	input	wire logic						moveEmpty,
	input	wire lanePkg::wbToken_t			moveToken,		// Buffer head
	input	wire lanePkg::data_t			moveData,
	output	logic							moveRead,		// Pop both buffers
	output	logic							wbValid,
	output	lanePkg::wbToken_t				wbToken,
	output	lanePkg::data_t					wbData
);

	import lanePkg::*;

	wbToken_t						selToken;
	data_t							selData;

	////////////////////
	// Arbitration
	////////////////////

	// A move leaves only once every older math result has written back
	assign moveRead				= ~moveEmpty & ~mathBusy & ~mathValid;

	assign selToken				= ( mathValid ) ?	mathToken : moveToken;
	assign selData				= ( mathValid ) ?	mathData : moveData;

	////////////////////
	// Output register
	////////////////////

	always_ff @(posedge clock) begin
		if ( rst ) begin
			wbValid		<= 1'b0;
		end else begin
			wbValid		<= mathValid | moveRead;
		end
	end

	always_ff @(posedge clock) begin
		wbToken		<= selToken;
		wbData		<= selData;
	end

endmodule

`default_nettype wire

// ==== verif/execLaneTb.sv ====
// Execution lane testbench: random commands checked against an in-order model
`timescale 1ns/1ps
`default_nettype none
`include "lane_defines.svh"

module execLaneTb;

	import lanePkg::*;

	localparam int NumArith		= 200;
	localparam int NumBurst		= 16;		// 4 math then 12 moves
	localparam int NumHeld		= 6;		// 4 math, 1 move, 1 math
	localparam int NumMix		= 400;
	localparam int CycleLimit	= 40 * ( NumArith + 1 + NumBurst + NumHeld + NumMix );

	logic			clock;
	logic			rst;
	logic			req;
	opCode_t		op;
	regIdx_t		dst;
	data_t			srcA;
	data_t			srcB;
	data_t			srcC;
	logic			issueStall;
	logic			wbValid;
	wbToken_t		wbToken;
	data_t			wbData;

	logic [31:0]	rngState;
	wbToken_t		expToken	[$];		// Model queue, issue order
	data_t			expData		[$];
	issueNo_t		nextIssueNo;
	int				errorCount	= 0;
	int				checkCount	= 0;
	int				cycleCount	= 0;

	execLane execLane_inst (
		.clock(clock), .rst(rst), .req(req), .op(op), .dst(dst),
		.srcA(srcA), .srcB(srcB), .srcC(srcC), .issueStall(issueStall),
		.wbValid(wbValid), .wbToken(wbToken), .wbData(wbData)
	);

	always #4 clock = ~clock;

	////////////////////
	// Model and checks
	////////////////////

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ ( x << 13 );
		x = x ^ ( x >> 17 );
		x = x ^ ( x << 5 );
		rngState = x;
		return x;
	endfunction

	function automatic data_t modelResult(input opCode_t cmdOp, input data_t a,
			input data_t b, input data_t c);
		case ( cmdOp )
			opAdd:		return a + b;
			opMul:		return a * b;			// Low 32 bits only
			opMac:		return a * b + c;
			default:	return a;				// Move copies srcA
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if ( actual !== expected ) begin
			$display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic checkWriteBack();
		wbToken_t token;
		data_t data;
		if ( expData.size() == 0 ) begin
			$display("Write-back with issue number %0d came with no command outstanding",
				wbToken.issueNo);
			errorCount++;
		end else begin
			token = expToken.pop_front();
			data = expData.pop_front();
			checkValue("wbToken.valid", wbToken.valid, token.valid);
			checkValue("wbToken.op", wbToken.op, token.op);
			checkValue("wbToken.dst", wbToken.dst, token.dst);
			checkValue("wbToken.issueNo", wbToken.issueNo, token.issueNo);
			checkValue("wbData", wbData, data);
		end
	endtask

	always @(negedge clock) begin
		if ( !rst && wbValid ) begin
			checkWriteBack();
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if ( cycleCount >= CycleLimit ) begin
			$display("Timeout after %0d cycles, %0d write-backs never arrived",
				cycleCount, expData.size());
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	// Holds the command until accepted, returns just after the accepting edge
	task automatic issueCmd(input opCode_t cmdOp, input regIdx_t cmdDst, input data_t a,
			input data_t b, input data_t c, output int stalls);
		logic accepted;
		wbToken_t token;
		accepted = 1'b0;
		stalls = 0;
		@(negedge clock);
		req = 1'b1;
		op = cmdOp;
		dst = cmdDst;
		srcA = a;
		srcB = b;
		srcC = c;
		while ( !accepted ) begin
			#2;									// Stall settled before the edge
			if ( issueStall ) begin
				stalls++;
				@(negedge clock);
			end else begin
				token.valid = 1'b1;
				token.op = cmdOp;
				token.dst = cmdDst;
				token.issueNo = nextIssueNo;
				expToken.push_back(token);
				expData.push_back(modelResult(cmdOp, a, b, c));
				nextIssueNo++;
				accepted = 1'b1;
			end
		end
		@(posedge clock);
	endtask

	task automatic randomCmd(input logic anyOp, output int stalls);
		logic [31:0] r;
		opCode_t cmdOp;
		data_t a;
		data_t b;
		data_t c;
		r = nextRandom();
		cmdOp = anyOp ? opCode_t'(r[1:0]) : opCode_t'(r % 3);
		a = nextRandom();
		b = nextRandom();
		c = nextRandom();
		issueCmd(cmdOp, regIdx_t'(r[7:4]), a, b, c, stalls);
	endtask

	task automatic idleCycles(input int n);
		repeat ( n ) begin
			@(negedge clock);
			req = 1'b0;
		end
	endtask

	task automatic drainLane();
		idleCycles(1);
		while ( expData.size() != 0 ) @(posedge clock);
		repeat ( 4 ) @(posedge clock);			// Room for a stray write-back
	endtask

	task automatic reportTest(input string name, input int commands, input int errorsBefore);
		$display("Test %s done: %0d commands, %0d errors", name, commands,
			errorCount - errorsBefore);
	endtask

	initial begin
		int errorsBefore;
		int stalls;
		int latency;
		logic [31:0] r;
		clock = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		op = opAdd;
		dst = '0;
		srcA = '0;
		srcB = '0;
		srcC = '0;
		rngState = 32'd23;
		nextIssueNo = '0;
		repeat ( 8 ) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		errorsBefore = errorCount;			// Arithmetic stream
		for ( int i = 0; i < NumArith; i++ ) randomCmd(1'b0, stalls);
		drainLane();
		reportTest("arithmetic stream", NumArith, errorsBefore);

		errorsBefore = errorCount;			// Latency into an idle lane
		issueCmd(opMac, 4'h3, nextRandom(), 32'd7, 32'd11, stalls);
		latency = 1;
		@(negedge clock);
		req = 1'b0;
		while ( !wbValid && latency < 20 ) begin
			@(posedge clock);
			latency++;
			@(negedge clock);
		end
		checkValue("wbValid latency", latency, `LANE_MATH_DEPTH + 1);
		drainLane();
		reportTest("arithmetic latency", 1, errorsBefore);

		errorsBefore = errorCount;			// Moves behind a draining math burst
		for ( int i = 0; i < 4; i++ ) randomCmd(1'b0, stalls);
		for ( int i = 0; i < NumBurst - 4; i++ ) begin
			r = nextRandom();
			issueCmd(opMov, regIdx_t'(i), r, 32'd0, 32'd0, stalls);
		end
		drainLane();
		reportTest("move burst", NumBurst, errorsBefore);

		errorsBefore = errorCount;			// Math waits for the queued move
		for ( int i = 0; i < 4; i++ ) randomCmd(1'b0, stalls);
		issueCmd(opMov, 4'h9, nextRandom(), 32'd0, 32'd0, stalls);
		issueCmd(opAdd, 4'ha, 32'd5, 32'd6, 32'd0, stalls);
		checkValue("issueStall seen", stalls > 0, 1);
		drainLane();
		reportTest("math held behind moves", NumHeld, errorsBefore);

		errorsBefore = errorCount;			// Mixed stream with gaps
		for ( int i = 0; i < NumMix; i++ ) begin
			randomCmd(1'b1, stalls);
			r = nextRandom();
			if ( r[2:0] == 3'd0 ) begin
				idleCycles(int'(r[4:3]) + 1);
			end
		end
		drainLane();
		reportTest("mixed stream", NumMix, errorsBefore);

		if ( execLane_inst.laneChecks.failCount != 0 ) begin
			$display("Lane checker saw %0d assertion failures",
				execLane_inst.laneChecks.failCount);
			errorCount += execLane_inst.laneChecks.failCount;
		end
		$display("Finished: %0d checks, %0d errors", checkCount, errorCount);
		if ( errorCount == 0 ) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/execLane_asserts.sv ====
// Lane assertions: reset quiet output, no push to a full buffer, in-order write-back
`timescale 1ns/1ps
`default_nettype none

module execLane_asserts (
	input	wire logic					clock,
	input	wire logic					rst,
	input	wire logic					wbValid,
	input	wire logic					moveWrite,
	input	wire logic					moveFull,
	input	wire lanePkg::wbToken_t		wbToken
);

	import lanePkg::*;

	issueNo_t						lastNo;			// Tag of the previous write-back
	issueNo_t						expectedNo;
	logic							haveLast;
	int								failCount = 0;	// Read by the testbench at the end

	assign expectedNo			= lastNo + 1'b1;	// Wraps at 16

	always_ff @(posedge clock) begin
		if ( rst ) begin
			haveLast	<= 1'b0;
			lastNo		<= '0;
		end else if ( wbValid ) begin
			haveLast	<= 1'b1;
			lastNo		<= wbToken.issueNo;
		end
	end

	resetQuiet: assert property ( @(posedge clock) rst |=> !wbValid )
		else begin
			failCount++;
			$error("wbValid high after a reset edge");
		end

	noPushFull: assert property ( @(posedge clock) disable iff ( rst )
		!( moveWrite && moveFull ) )
		else begin
			failCount++;
			$error("Move written while the move buffer is full");
		end

	inOrder: assert property ( @(posedge clock) disable iff ( rst )
		( wbValid && haveLast ) |-> ( wbToken.issueNo == expectedNo ) )
		else begin
			failCount++;
			$error("Write-back issue number 0x%h, expected 0x%h", wbToken.issueNo, expectedNo);
		end

endmodule

bind execLane execLane_asserts laneChecks (
	.clock(clock), .rst(rst), .wbValid(wbValid), .moveWrite(moveWrite),
	.moveFull(moveFull), .wbToken(wbToken)
);

`default_nettype wire
